//--- mem_req_macros.svh
`ifndef MEM_REQ_MACROS_SVH
`define MEM_REQ_MACROS_SVH

// requesters on the miss path: ifetch, data, writeback
`define NUM_REQUEST 3

// one packed request as seen by the arbiter
`define REQUEST_WIDTH 64

// arbitration slots a just-granted way stays blocked
`define SAME_WAY_LOCK_CYCLE 4

// backing store geometry
`define MEM_ADDR_WIDTH 4
`define MEM_DATA_WIDTH 32
`define MEM_DEPTH (1 << `MEM_ADDR_WIDTH)

// busy cycles per request in the backend
`define MEM_LATENCY 3

`endif

//--- mem_req_pkg.sv
`include "mem_req_macros.svh"

package mem_req_pkg;

    typedef enum logic [1:0]
    {
        MEM_READ  = 2'd0,
        MEM_WRITE = 2'd1
    } mem_opcode_e;

    typedef enum logic [1:0]
    {
        BACKEND_IDLE    = 2'd0,
        BACKEND_BUSY    = 2'd1,
        BACKEND_RESPOND = 2'd2
    } backend_state_e;

    // request layout, opcode on top and data at the bottom
    localparam int OPCODE_MSB   = `REQUEST_WIDTH - 1;
    localparam int OPCODE_LSB   = `REQUEST_WIDTH - 2;
    localparam int SOURCE_WIDTH = 2;
    localparam int SOURCE_MSB   = OPCODE_LSB - 1;
    localparam int SOURCE_LSB   = OPCODE_LSB - SOURCE_WIDTH;
    localparam int ADDR_MSB     = SOURCE_LSB - 1;
    localparam int ADDR_LSB     = SOURCE_LSB - `MEM_ADDR_WIDTH;
    localparam int DATA_MSB     = `MEM_DATA_WIDTH - 1;
    localparam int DATA_LSB     = 0;

endpackage

//--- request_port.sv
`timescale 1ns/1ns
`include "mem_req_macros.svh"

module request_port
    import mem_req_pkg::*;
#(
    parameter logic [SOURCE_WIDTH-1:0] SOURCE_ID = '0
)
(
    input  logic                        clk_in,
    input  logic                        reset_in,

    input  logic                        req_valid,
    output logic                        req_ready,
    input  mem_opcode_e                 req_opcode,
    input  logic                        req_critical,
    input  logic [`MEM_ADDR_WIDTH-1:0]  req_addr,
    input  logic [`MEM_DATA_WIDTH-1:0]  req_data,

    input  logic                        issue_ack,
    output logic [`REQUEST_WIDTH-1:0]   request,
    output logic                        request_valid,
    output logic                        request_critical
);

logic                       full;
logic                       accept;
logic [`REQUEST_WIDTH-1:0]  packed_request;

assign req_ready     = !full;
assign request_valid = full;
assign accept        = req_valid && req_ready;

// unused middle bits stay zero
always_comb
begin
    packed_request                        = '0;
    packed_request[OPCODE_MSB:OPCODE_LSB] = req_opcode;
    packed_request[SOURCE_MSB:SOURCE_LSB] = SOURCE_ID;
    packed_request[ADDR_MSB:ADDR_LSB]     = req_addr;
    packed_request[DATA_MSB:DATA_LSB]     = req_data;
end

always_ff @(posedge clk_in or posedge reset_in)
begin
    if (reset_in)
    begin
        full             <= 1'b0;
        request_critical <= 1'b0;
    end
    else if (accept)
    begin
        full             <= 1'b1;
        request_critical <= req_critical;
    end
    else if (issue_ack)
    begin
        full <= 1'b0;
    end
end

always_ff @(posedge clk_in)
begin
    if (accept)
    begin
        request <= packed_request;
    end
end

// the arbiter only acknowledges a way it actually granted
ack_only_when_full: assert property (@(posedge clk_in) disable iff (reset_in)
    issue_ack |-> full);

endmodule

//--- priority_arbiter.sv
`timescale 1ns/1ns
`include "mem_req_macros.svh"

module priority_arbiter
(
    input  logic                                        clk_in,
    input  logic                                        reset_in,

    input  logic [`REQUEST_WIDTH*`NUM_REQUEST-1:0]      request_flatted_in,
    input  logic [`NUM_REQUEST-1:0]                     request_valid_flatted_in,
    input  logic [`NUM_REQUEST-1:0]                     request_critical_flatted_in,
    output logic [`NUM_REQUEST-1:0]                     issue_ack_out,

    output logic [`REQUEST_WIDTH-1:0]                   request_out,
    output logic                                        request_valid_out,
    input  logic                                        issue_ack_in
);

localparam int WAY_IDX_WIDTH = $clog2(`NUM_REQUEST);
localparam int LOCK_WIDTH    = $clog2(`SAME_WAY_LOCK_CYCLE + 1);

logic [WAY_IDX_WIDTH-1:0]       last_send_index;
logic [LOCK_WIDTH-1:0]          same_way_lock [`NUM_REQUEST];
logic [`REQUEST_WIDTH-1:0]      request_way [`NUM_REQUEST];

logic [2*`NUM_REQUEST-1:0]      valid_doubled;
logic [2*`NUM_REQUEST-1:0]      critical_doubled;
logic [`NUM_REQUEST-1:0]        valid_rotated;
logic [`NUM_REQUEST-1:0]        critical_rotated;

logic [WAY_IDX_WIDTH-1:0]       valid_sel;
logic [WAY_IDX_WIDTH-1:0]       critical_sel;
logic [WAY_IDX_WIDTH-1:0]       grant_sel;
logic                           valid_found;
logic                           critical_found;
logic                           grant_candidate;
logic                           grant_blocked;
logic                           grant_fire;
logic                           slot_free;
logic [`NUM_REQUEST-1:0]        grant_onehot;

// maps a position in the rotated vector back to a way index
function automatic logic [WAY_IDX_WIDTH-1:0] way_index(
    input logic [WAY_IDX_WIDTH-1:0] base,
    input int                       offset
);
    int sum;
    sum = int'(base) + offset + 1;
    if (sum >= `NUM_REQUEST)
    begin
        sum = sum - `NUM_REQUEST;
    end
    return sum[WAY_IDX_WIDTH-1:0];
endfunction

always_comb
begin
    for (int i = 0; i < `NUM_REQUEST; i++)
    begin
        request_way[i] = request_flatted_in[i*`REQUEST_WIDTH +: `REQUEST_WIDTH];
    end
end

// bit 0 of the rotated vectors is the way right after the last grant
assign valid_doubled    = {request_valid_flatted_in, request_valid_flatted_in};
assign critical_doubled = {request_critical_flatted_in, request_critical_flatted_in};
assign valid_rotated    = `NUM_REQUEST'(valid_doubled >> (last_send_index + 1'b1));
assign critical_rotated = `NUM_REQUEST'(critical_doubled >> (last_send_index + 1'b1));

always_comb
begin
    valid_found    = 1'b0;
    critical_found = 1'b0;
    valid_sel      = '0;
    critical_sel   = '0;
    for (int i = 0; i < `NUM_REQUEST; i++)
    begin
        if (valid_rotated[i] && !valid_found)
        begin
            valid_found = 1'b1;
            valid_sel   = way_index(last_send_index, i);
        end
        if (valid_rotated[i] && critical_rotated[i] && !critical_found)
        begin
            critical_found = 1'b1;
            critical_sel   = way_index(last_send_index, i);
        end
    end
end

assign grant_sel       = critical_found ? critical_sel : valid_sel;
assign grant_candidate = critical_found || valid_found;
// the granted way's valid is still up while its ack travels back
assign grant_blocked   = (grant_sel == last_send_index) && (same_way_lock[grant_sel] != '0);
assign slot_free       = !request_valid_out || issue_ack_in;
assign grant_fire      = slot_free && grant_candidate && !grant_blocked;

always_comb
begin
    grant_onehot            = '0;
    grant_onehot[grant_sel] = 1'b1;
end

always_ff @(posedge clk_in or posedge reset_in)
begin
    if (reset_in)
    begin
        request_valid_out <= 1'b0;
        issue_ack_out     <= '0;
        last_send_index   <= '0;
        for (int i = 0; i < `NUM_REQUEST; i++)
        begin
            same_way_lock[i] <= '0;
        end
    end
    else if (grant_fire)
    begin
        request_valid_out <= 1'b1;
        issue_ack_out     <= grant_onehot;
        last_send_index   <= grant_sel;
        same_way_lock[grant_sel] <= LOCK_WIDTH'(`SAME_WAY_LOCK_CYCLE);
    end
    else if (slot_free)
    begin
        // locks run down while the slot is empty
        request_valid_out <= 1'b0;
        issue_ack_out     <= '0;
        for (int i = 0; i < `NUM_REQUEST; i++)
        begin
            if (same_way_lock[i] != '0)
            begin
                same_way_lock[i] <= same_way_lock[i] - 1'b1;
            end
        end
    end
    else
    begin
        issue_ack_out <= '0;
    end
end

always_ff @(posedge clk_in)
begin
    if (grant_fire)
    begin
        request_out <= request_way[grant_sel];
    end
end

// backend stall must not disturb the pending request
hold_while_stalled: assert property (@(posedge clk_in) disable iff (reset_in)
    request_valid_out && !issue_ack_in |=> request_valid_out && $stable(request_out));

// at most one way acknowledged per cycle and never the same way twice in a row
ack_onehot: assert property (@(posedge clk_in) disable iff (reset_in)
    $onehot0(issue_ack_out) && ((issue_ack_out & $past(issue_ack_out)) == '0));

endmodule

//--- memory_backend.sv
`timescale 1ns/1ns
`include "mem_req_macros.svh"

module memory_backend
    import mem_req_pkg::*;
(
    input  logic                        clk_in,
    input  logic                        reset_in,

    input  logic [`REQUEST_WIDTH-1:0]   request_in,
    input  logic                        request_valid_in,
    output logic                        issue_ack_out,

    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output logic [SOURCE_WIDTH-1:0]     rsp_source,
    output logic [`MEM_DATA_WIDTH-1:0]  rsp_data
);

localparam int COUNT_WIDTH = $clog2(`MEM_LATENCY + 1);

backend_state_e                 state;
logic [COUNT_WIDTH-1:0]         latency_count;
logic                           accept;
logic                           access_now;

mem_opcode_e                    opcode_q;
logic [`MEM_ADDR_WIDTH-1:0]     addr_q;
logic [`MEM_DATA_WIDTH-1:0]     data_q;
logic [`MEM_DATA_WIDTH-1:0]     store [`MEM_DEPTH];

assign issue_ack_out = (state == BACKEND_IDLE);
assign rsp_valid     = (state == BACKEND_RESPOND);
assign accept        = issue_ack_out && request_valid_in;
// latency countdown done, store access happens on this edge
assign access_now    = (state == BACKEND_BUSY) && (latency_count == '0);

always_ff @(posedge clk_in or posedge reset_in)
begin
    if (reset_in)
    begin
        state         <= BACKEND_IDLE;
        latency_count <= '0;
        for (int i = 0; i < `MEM_DEPTH; i++)
        begin
            store[i] <= '0;
        end
    end
    else
    begin
        case (state)
            BACKEND_IDLE:
            begin
                if (request_valid_in)
                begin
                    state         <= BACKEND_BUSY;
                    latency_count <= COUNT_WIDTH'(`MEM_LATENCY);
                end
            end
            BACKEND_BUSY:
            begin
                if (latency_count != '0)
                begin
                    latency_count <= latency_count - 1'b1;
                end
                else
                begin
                    state <= BACKEND_RESPOND;
                    if (opcode_q == MEM_WRITE)
                    begin
                        store[addr_q] <= data_q;
                    end
                end
            end
            BACKEND_RESPOND:
            begin
                if (rsp_ready)
                begin
                    state <= BACKEND_IDLE;
                end
            end
            default:
            begin
                state <= BACKEND_IDLE;
            end
        endcase
    end
end

always_ff @(posedge clk_in)
begin
    if (accept)
    begin
        opcode_q   <= mem_opcode_e'(request_in[OPCODE_MSB:OPCODE_LSB]);
        rsp_source <= request_in[SOURCE_MSB:SOURCE_LSB];
        addr_q     <= request_in[ADDR_MSB:ADDR_LSB];
        data_q     <= request_in[DATA_MSB:DATA_LSB];
    end
    if (access_now)
    begin
        rsp_data <= (opcode_q == MEM_WRITE) ? data_q : store[addr_q];
    end
end

rsp_held_until_taken: assert property (@(posedge clk_in) disable iff (reset_in)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data) && $stable(rsp_source));

endmodule

//--- mem_req_top.sv
`timescale 1ns/1ns
`include "mem_req_macros.svh"

module mem_req_top
    import mem_req_pkg::*;
(
    input  logic                        clk_in,
    input  logic                        reset_in,

    input  logic                        ifetch_valid,
    output logic                        ifetch_ready,
    input  mem_opcode_e                 ifetch_opcode,
    input  logic                        ifetch_critical,
    input  logic [`MEM_ADDR_WIDTH-1:0]  ifetch_addr,
    input  logic [`MEM_DATA_WIDTH-1:0]  ifetch_data,

    input  logic                        data_valid,
    output logic                        data_ready,
    input  mem_opcode_e                 data_opcode,
    input  logic                        data_critical,
    input  logic [`MEM_ADDR_WIDTH-1:0]  data_addr,
    input  logic [`MEM_DATA_WIDTH-1:0]  data_data,

    input  logic                        wb_valid,
    output logic                        wb_ready,
    input  mem_opcode_e                 wb_opcode,
    input  logic                        wb_critical,
    input  logic [`MEM_ADDR_WIDTH-1:0]  wb_addr,
    input  logic [`MEM_DATA_WIDTH-1:0]  wb_data,

    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output logic [SOURCE_WIDTH-1:0]     rsp_source,
    output logic [`MEM_DATA_WIDTH-1:0]  rsp_data
);

logic [`REQUEST_WIDTH*`NUM_REQUEST-1:0] request_flatted;
logic [`NUM_REQUEST-1:0]                request_valid_flatted;
logic [`NUM_REQUEST-1:0]                request_critical_flatted;
logic [`NUM_REQUEST-1:0]                issue_ack;
logic [`REQUEST_WIDTH-1:0]              arb_request;
logic                                   arb_request_valid;
logic                                   backend_ack;

// way 0 ifetch, way 1 data, way 2 writeback
request_port #(.SOURCE_ID(2'd0)) i_ifetch_port (
    .clk_in(clk_in), .reset_in(reset_in),
    .req_valid(ifetch_valid), .req_ready(ifetch_ready), .req_opcode(ifetch_opcode),
    .req_critical(ifetch_critical), .req_addr(ifetch_addr), .req_data(ifetch_data),
    .issue_ack(issue_ack[0]),
    .request(request_flatted[0*`REQUEST_WIDTH +: `REQUEST_WIDTH]),
    .request_valid(request_valid_flatted[0]),
    .request_critical(request_critical_flatted[0])
);

request_port #(.SOURCE_ID(2'd1)) i_data_port (
    .clk_in(clk_in), .reset_in(reset_in),
    .req_valid(data_valid), .req_ready(data_ready), .req_opcode(data_opcode),
    .req_critical(data_critical), .req_addr(data_addr), .req_data(data_data),
    .issue_ack(issue_ack[1]),
    .request(request_flatted[1*`REQUEST_WIDTH +: `REQUEST_WIDTH]),
    .request_valid(request_valid_flatted[1]),
    .request_critical(request_critical_flatted[1])
);

request_port #(.SOURCE_ID(2'd2)) i_wb_port (
    .clk_in(clk_in), .reset_in(reset_in),
    .req_valid(wb_valid), .req_ready(wb_ready), .req_opcode(wb_opcode),
    .req_critical(wb_critical), .req_addr(wb_addr), .req_data(wb_data),
    .issue_ack(issue_ack[2]),
    .request(request_flatted[2*`REQUEST_WIDTH +: `REQUEST_WIDTH]),
    .request_valid(request_valid_flatted[2]),
    .request_critical(request_critical_flatted[2])
);

priority_arbiter i_arbiter (
    .clk_in(clk_in), .reset_in(reset_in),
    .request_flatted_in(request_flatted),
    .request_valid_flatted_in(request_valid_flatted),
    .request_critical_flatted_in(request_critical_flatted),
    .issue_ack_out(issue_ack),
    .request_out(arb_request),
    .request_valid_out(arb_request_valid),
    .issue_ack_in(backend_ack)
);

memory_backend i_backend (
    .clk_in(clk_in), .reset_in(reset_in),
    .request_in(arb_request), .request_valid_in(arb_request_valid),
    .issue_ack_out(backend_ack),
    .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
    .rsp_source(rsp_source), .rsp_data(rsp_data)
);

endmodule

//--- tb_mem_req_top.sv
`timescale 1ns/1ns
`include "mem_req_macros.svh"

module tb_mem_req_top
    import mem_req_pkg::*;
();

localparam int CLK_PERIOD      = 20;
localparam int RESET_CYCLES    = 10;
localparam int ZERO_READS      = `MEM_DEPTH;
localparam int RAW_PAIRS       = 8;
localparam int RANDOM_REQUESTS = 60;
localparam int BP_REQUESTS     = 80;
localparam int TOTAL_REQUESTS  = ZERO_READS + 2 * RAW_PAIRS + RANDOM_REQUESTS
                                 + 2 * `NUM_REQUEST + BP_REQUESTS;
localparam int WATCHDOG_CYCLES = TOTAL_REQUESTS * (`MEM_LATENCY + 10 + `NUM_REQUEST * 2);

typedef struct packed
{
    logic                       is_write;
    logic [`MEM_ADDR_WIDTH-1:0] addr;
    logic [`MEM_DATA_WIDTH-1:0] data;
} pending_t;

logic                       clk_in;
logic                       reset_in;
logic                       req_valid    [`NUM_REQUEST];
logic                       req_ready    [`NUM_REQUEST];
mem_opcode_e                req_opcode   [`NUM_REQUEST];
logic                       req_critical [`NUM_REQUEST];
logic [`MEM_ADDR_WIDTH-1:0] req_addr     [`NUM_REQUEST];
logic [`MEM_DATA_WIDTH-1:0] req_data     [`NUM_REQUEST];
logic                       rsp_valid;
logic                       rsp_ready;
logic [SOURCE_WIDTH-1:0]    rsp_source;
logic [`MEM_DATA_WIDTH-1:0] rsp_data;

integer                     seed = 32'hc665_bd34;

// reference model: memory in backend order, one queue of outstanding requests per source
logic [`MEM_DATA_WIDTH-1:0] model_mem [`MEM_DEPTH];
pending_t                   pending_q [`NUM_REQUEST][$];
logic [SOURCE_WIDTH-1:0]    rsp_order [$];
logic                       req_fire  [`NUM_REQUEST];
logic                       rsp_held;
logic [SOURCE_WIDTH-1:0]    held_source;
logic [`MEM_DATA_WIDTH-1:0] held_data;
int                         accepted_count = 0;
int                         response_count = 0;
int                         check_count = 0;
int                         error_count = 0;
int                         tests_run = 0;
int                         tests_bad = 0;

mem_req_top i_dut (
    .clk_in(clk_in), .reset_in(reset_in),
    .ifetch_valid(req_valid[0]), .ifetch_ready(req_ready[0]), .ifetch_opcode(req_opcode[0]),
    .ifetch_critical(req_critical[0]), .ifetch_addr(req_addr[0]), .ifetch_data(req_data[0]),
    .data_valid(req_valid[1]), .data_ready(req_ready[1]), .data_opcode(req_opcode[1]),
    .data_critical(req_critical[1]), .data_addr(req_addr[1]), .data_data(req_data[1]),
    .wb_valid(req_valid[2]), .wb_ready(req_ready[2]), .wb_opcode(req_opcode[2]),
    .wb_critical(req_critical[2]), .wb_addr(req_addr[2]), .wb_data(req_data[2]),
    .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
    .rsp_source(rsp_source), .rsp_data(rsp_data)
);

initial
begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
end

initial
begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("test failed");
    $finish;
end

function automatic int rand_below(input int n);
    return int'({$random(seed)} % n);
endfunction

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    check_count++;
    if (actual !== expected)
    begin
        error_count++;
        $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h at %0t",
                 name, actual, expected, $time);
    end
endtask

function automatic bit queues_empty();
    for (int s = 0; s < `NUM_REQUEST; s++)
    begin
        if (pending_q[s].size() != 0)
        begin
            return 1'b0;
        end
    end
    return 1'b1;
endfunction

// a response is taken on the next rising edge, so pop the oldest request of its source
task automatic take_response();
    pending_t                   entry;
    logic [`MEM_DATA_WIDTH-1:0] expected;
    int                         src;
    src = int'(rsp_source);
    rsp_order.push_back(rsp_source);
    response_count++;
    if (src >= `NUM_REQUEST || pending_q[src].size() == 0)
    begin
        error_count++;
        $display("response from source %0d with no request outstanding at %0t", src, $time);
    end
    else
    begin
        entry = pending_q[src].pop_front();
        if (entry.is_write)
        begin
            model_mem[entry.addr] = entry.data;
            expected = entry.data;
        end
        else
        begin
            expected = model_mem[entry.addr];
        end
        check_value("rsp_data", rsp_data, expected);
    end
endtask

// handshakes sampled mid-cycle, when everything driven at the edge has settled
always @(negedge clk_in)
begin : watch_handshakes
    pending_t entry;
    if (reset_in)
    begin
        for (int s = 0; s < `NUM_REQUEST; s++)
        begin
            req_fire[s] = 1'b0;
        end
        rsp_held = 1'b0;
    end
    else
    begin
        for (int s = 0; s < `NUM_REQUEST; s++)
        begin
            req_fire[s] = req_valid[s] && req_ready[s];
            if (req_fire[s])
            begin
                entry.is_write = (req_opcode[s] == MEM_WRITE);
                entry.addr     = req_addr[s];
                entry.data     = req_data[s];
                pending_q[s].push_back(entry);
                accepted_count++;
            end
        end
        if (rsp_held)
        begin
            if (!rsp_valid)
            begin
                error_count++;
                $display("rsp_valid dropped before the response was taken at %0t", $time);
            end
            else
            begin
                check_value("rsp_data", rsp_data, held_data);
                check_value("rsp_source", 32'(rsp_source), 32'(held_source));
            end
        end
        rsp_held    = rsp_valid && !rsp_ready;
        held_data   = rsp_data;
        held_source = rsp_source;
        if (rsp_valid && rsp_ready)
        begin
            take_response();
        end
    end
end

task automatic apply_reset();
    @(posedge clk_in);
    reset_in  <= 1'b1;
    rsp_ready <= 1'b1;
    for (int s = 0; s < `NUM_REQUEST; s++)
    begin
        req_valid[s] <= 1'b0;
        pending_q[s].delete();
    end
    for (int a = 0; a < `MEM_DEPTH; a++)
    begin
        model_mem[a] = '0;
    end
    rsp_order.delete();
    accepted_count = 0;
    response_count = 0;
    repeat (RESET_CYCLES) @(posedge clk_in);
    reset_in <= 1'b0;
    @(posedge clk_in);
endtask

task automatic send_request(input int src, input mem_opcode_e op, input logic critical,
                            input logic [`MEM_ADDR_WIDTH-1:0] addr,
                            input logic [`MEM_DATA_WIDTH-1:0] data);
    @(posedge clk_in);
    req_valid[src]    <= 1'b1;
    req_opcode[src]   <= op;
    req_critical[src] <= critical;
    req_addr[src]     <= addr;
    req_data[src]     <= data;
    @(posedge clk_in);
    while (!req_fire[src])
    begin
        @(posedge clk_in);
    end
    req_valid[src] <= 1'b0;
endtask

task automatic wait_drain();
    while (!queues_empty())
    begin
        @(posedge clk_in);
    end
    @(posedge clk_in);
endtask

task automatic present_random(input int s);
    req_valid[s]    <= 1'b1;
    req_opcode[s]   <= (rand_below(2) == 0) ? MEM_READ : MEM_WRITE;
    req_critical[s] <= (rand_below(4) == 0);
    req_addr[s]     <= `MEM_ADDR_WIDTH'(rand_below(`MEM_DEPTH));
    req_data[s]     <= $random(seed);
endtask

// all three ports loaded on one edge with reads
task automatic load_all(input logic [`NUM_REQUEST-1:0] critical_mask);
    logic [`NUM_REQUEST-1:0] waiting;
    @(posedge clk_in);
    for (int s = 0; s < `NUM_REQUEST; s++)
    begin
        req_valid[s]    <= 1'b1;
        req_opcode[s]   <= MEM_READ;
        req_critical[s] <= critical_mask[s];
        req_addr[s]     <= `MEM_ADDR_WIDTH'(rand_below(`MEM_DEPTH));
        req_data[s]     <= '0;
    end
    waiting = '1;
    while (waiting != '0)
    begin
        @(posedge clk_in);
        for (int s = 0; s < `NUM_REQUEST; s++)
        begin
            if (waiting[s] && req_fire[s])
            begin
                req_valid[s] <= 1'b0;
                waiting[s]   = 1'b0;
            end
        end
    end
    wait_drain();
endtask

task automatic run_traffic(input int total, input bit backpressure);
    int issued;
    int accepted_start;
    int stall_left;
    issued         = 0;
    accepted_start = accepted_count;
    stall_left     = 0;
    while (issued < total || accepted_count - accepted_start < total || !queues_empty())
    begin
        @(posedge clk_in);
        for (int s = 0; s < `NUM_REQUEST; s++)
        begin
            if (!req_valid[s] || req_fire[s])
            begin
                if (issued < total && rand_below(3) != 0)
                begin
                    present_random(s);
                    issued++;
                end
                else
                begin
                    req_valid[s] <= 1'b0;
                end
            end
        end
        if (!backpressure)
        begin
            rsp_ready <= 1'b1;
        end
        else if (stall_left > 0)
        begin
            stall_left--;
            rsp_ready <= 1'b0;
        end
        else if (rand_below(4) == 0)
        begin
            stall_left = rand_below(6);
            rsp_ready <= 1'b0;
        end
        else
        begin
            rsp_ready <= 1'b1;
        end
    end
    rsp_ready <= 1'b1;
endtask

task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before)
    begin
        $display("%s: ok", name);
    end
    else
    begin
        tests_bad++;
        $display("%s: %0d errors", name, error_count - errors_before);
    end
endtask

initial
begin
    int                         errors_before;
    logic [`MEM_ADDR_WIDTH-1:0] raw_addr [RAW_PAIRS];
    reset_in  = 1'b1;
    rsp_ready = 1'b1;
    rsp_held  = 1'b0;
    for (int s = 0; s < `NUM_REQUEST; s++)
    begin
        req_valid[s]    = 1'b0;
        req_opcode[s]   = MEM_READ;
        req_critical[s] = 1'b0;
        req_addr[s]     = '0;
        req_data[s]     = '0;
        req_fire[s]     = 1'b0;
    end
    apply_reset();

    errors_before = error_count;
    @(negedge clk_in);
    check_value("ifetch_ready", 32'(req_ready[0]), 32'd1);
    check_value("data_ready", 32'(req_ready[1]), 32'd1);
    check_value("wb_ready", 32'(req_ready[2]), 32'd1);
    check_value("rsp_valid", 32'(rsp_valid), 32'd0);
    for (int a = 0; a < ZERO_READS; a++)
    begin
        send_request(0, MEM_READ, 1'b0, `MEM_ADDR_WIDTH'(a), '0);
    end
    wait_drain();
    finish_test("reset_state", errors_before);

    // writes then reads of the same addresses, all from the data port
    errors_before = error_count;
    for (int i = 0; i < RAW_PAIRS; i++)
    begin
        raw_addr[i] = `MEM_ADDR_WIDTH'(rand_below(`MEM_DEPTH));
        send_request(1, MEM_WRITE, 1'b0, raw_addr[i], $random(seed));
    end
    for (int i = 0; i < RAW_PAIRS; i++)
    begin
        send_request(1, MEM_READ, 1'b0, raw_addr[i], '0);
    end
    wait_drain();
    finish_test("read_after_write", errors_before);

    errors_before = error_count;
    run_traffic(RANDOM_REQUESTS, 1'b0);
    finish_test("response_source", errors_before);

    // search starts after way 0 following reset
    errors_before = error_count;
    apply_reset();
    load_all('0);
    if (rsp_order.size() < 3)
    begin
        error_count++;
        $display("round robin saw only %0d responses", rsp_order.size());
    end
    else
    begin
        check_value("rsp_source", 32'(rsp_order[0]), 32'd1);
        check_value("rsp_source", 32'(rsp_order[1]), 32'd2);
        check_value("rsp_source", 32'(rsp_order[2]), 32'd0);
    end
    finish_test("round_robin", errors_before);

    errors_before = error_count;
    apply_reset();
    load_all(`NUM_REQUEST'(3'b100));
    if (rsp_order.size() == 0)
    begin
        error_count++;
        $display("critical priority saw no response");
    end
    else
    begin
        check_value("rsp_source", 32'(rsp_order[0]), 32'd2);
    end
    finish_test("critical_priority", errors_before);

    errors_before = error_count;
    run_traffic(BP_REQUESTS, 1'b1);
    check_value("response_count", 32'(response_count), 32'(accepted_count));
    finish_test("back_pressure", errors_before);

    $display("summary: %0d tests run, %0d with errors, %0d checks, %0d errors",
             tests_run, tests_bad, check_count, error_count);
    if (error_count == 0)
    begin
        $display("test passed");
    end
    else
    begin
        $display("test failed");
    end
    $finish;
end

endmodule

//--- files.f
+incdir+.
mem_req_pkg.sv
request_port.sv
priority_arbiter.sv
memory_backend.sv
mem_req_top.sv
tb_mem_req_top.sv

//--- Makefile
VERILATOR := verilator
TOP       := tb_mem_req_top
FILELIST  := files.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
PASS_MSG  := test passed

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation output is searched for the pass line, grep sets the exit status
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
